// File: build.f
icache_pkg.sv
icache_line_store.sv
icache_ctrl.sv
icache_perf_count.sv
fetch_cache_top.sv
fetch_cache_checker.sv
tb_fetch_cache.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the fetch cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_fetch_cache \
    -f build.f -o sim_fetch_cache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_fetch_cache)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// File: tb_fetch_cache.sv
`timescale 1ns/100ps

module tb_fetch_cache;

    import icache_pkg::*;

    localparam int index_width = 2;
    localparam int line_sel_width = 1;
    localparam int num_lines = 2 ** index_width;
    localparam int index_lsb = offset_width + line_sel_width;
    localparam int tag_lsb = index_lsb + index_width;
    localparam int wait_limit = 200;

    logic clock, reset, flush;
    logic ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready, ifu_rlast;
    addr_t ifu_araddr, mem_araddr;
    word_t ifu_rdata, mem_rdata;
    logic mem_arvalid, mem_arready, mem_rvalid, mem_rready, mem_rlast;
    logic [7:0] mem_arlen;
    logic [1:0] mem_arburst;
    perf_count_t hit_count, miss_count, bypass_count;

    integer seed = 32'ha24b8694;
    int error_count = 0;
    int exp_hits = 0;
    int exp_misses = 0;
    int exp_bypasses = 0;
    int burst_count = 0;
    bit outstanding = 0;
    bit timed_out = 0;
    addr_t last_ar_addr;
    logic [7:0] last_ar_len;
    logic [1:0] last_ar_burst;
    bit ref_valid [num_lines];
    addr_t ref_tag [num_lines];

    fetch_cache_top #(
        .index_width    (index_width),
        .line_sel_width (line_sel_width)
    ) u_fetch_cache_top (.*);

    bind icache_ctrl fetch_cache_checker u_checker (
        .clock (clock), .reset (reset), .state (state), .ifu_araddr (ifu_araddr),
        .ifu_rvalid (ifu_rvalid), .ifu_rready (ifu_rready), .ifu_rdata (ifu_rdata),
        .mem_arvalid (mem_arvalid), .mem_arready (mem_arready), .mem_araddr (mem_araddr),
        .mem_arlen (mem_arlen), .mem_rvalid (mem_rvalid), .mem_rlast (mem_rlast)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Memory contents, a fixed mix of all address bits
    function automatic word_t mem_word(input addr_t addr);
        return {addr[15:0], addr[31:16]} ^ (addr * 32'h9e3779b1) ^ 32'h5ac33c5a;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    // Predicts hit or miss and allocates the line on a miss
    function automatic bit ref_lookup(input addr_t addr);
        int index;
        addr_t tag;
        index = int'(addr[tag_lsb-1:index_lsb]);
        tag = addr >> tag_lsb;
        if (ref_valid[index] && ref_tag[index] == tag) begin
            return 1'b1;
        end
        ref_valid[index] = 1'b1;
        ref_tag[index] = tag;
        return 1'b0;
    endfunction

    // ------------------------------------------------------------
    // Memory model
    // ------------------------------------------------------------

    initial begin
        int delay;
        forever begin
            @(negedge clock);
            if (!reset && mem_arvalid && mem_arready) begin
                last_ar_addr = mem_araddr;
                last_ar_len = mem_arlen;
                last_ar_burst = mem_arburst;
                burst_count++;
                @(posedge clock);
                mem_arready <= 1'b0;
                delay = ($random(seed) & 3);
                repeat (delay) @(posedge clock);
                for (int k = 0; k <= int'(last_ar_len); k++) begin
                    mem_rvalid <= 1'b1;
                    mem_rdata <= mem_word(last_ar_addr + addr_t'(4 * k));
                    mem_rlast <= (k == int'(last_ar_len));
                    @(posedge clock);
                end
                mem_rvalid <= 1'b0;
                mem_rlast <= 1'b0;
            end else begin
                @(posedge clock);
                mem_arready <= rand_bit();
            end
        end
    end

    // Compares every fetch-side read transfer
    always @(negedge clock) begin
        if (!reset && ifu_rvalid && ifu_rready) begin
            if (!outstanding) begin
                $display("Response at %0t with no fetch pending for %h", $time, ifu_araddr);
                error_count++;
            end
            if (ifu_rdata !== mem_word(ifu_araddr)) begin
                $display("[FAIL] %0t ifu_rdata expected %h actual %h",
                         $time, mem_word(ifu_araddr), ifu_rdata);
                error_count++;
            end
            if (ifu_rlast !== 1'b1) begin
                $display("[FAIL] %0t ifu_rlast expected 1 actual %b", $time, ifu_rlast);
                error_count++;
            end
            outstanding = 1'b0;
        end
        // Refill and bypass beats are always accepted
        if (!reset && mem_rready !== 1'b1) begin
            $display("[FAIL] %0t mem_rready expected 1 actual %b", $time, mem_rready);
            error_count++;
        end
    end

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_counters();
        check_value("hit_count", exp_hits, int'(hit_count));
        check_value("miss_count", exp_misses, int'(miss_count));
        check_value("bypass_count", exp_bypasses, int'(bypass_count));
    endtask

    task automatic pulse_flush();
        @(posedge clock);
        flush <= 1'b1;
        @(posedge clock);
        flush <= 1'b0;
        for (int i = 0; i < num_lines; i++) begin
            ref_valid[i] = 1'b0;
        end
    endtask

    // ------------------------------------------------------------
    // One fetch, with optional ready stalls on cacheable reads
    // ------------------------------------------------------------

    task automatic run_fetch(input addr_t addr, input bit stalls);
        bit cacheable;
        bit exp_hit;
        int cycles;
        int bursts_before;
        cacheable = (addr[31:24] == cacheable_base);
        exp_hit = cacheable ? ref_lookup(addr) : 1'b0;
        bursts_before = burst_count;
        @(posedge clock);
        ifu_arvalid <= 1'b1;
        ifu_araddr <= addr;
        cycles = 0;
        forever begin
            @(negedge clock);
            if (ifu_arvalid && ifu_arready) break;
            cycles++;
            if (cycles > wait_limit) begin
                $display("Timeout: fetch address %h was never accepted", addr);
                error_count++;
                timed_out = 1'b1;
                return;
            end
        end
        if (!cacheable) exp_bypasses++;
        else if (exp_hit) exp_hits++;
        else exp_misses++;
        @(posedge clock);
        ifu_arvalid <= 1'b0;
        ifu_rready <= (stalls && cacheable) ? rand_bit() : 1'b1;
        outstanding = 1'b1;
        cycles = 0;
        forever begin
            @(negedge clock);
            cycles++;
            if (ifu_rvalid && ifu_rready) break;
            if (cycles > wait_limit) begin
                $display("Timeout: no read response for fetch address %h", addr);
                error_count++;
                timed_out = 1'b1;
                return;
            end
            @(posedge clock);
            ifu_rready <= (stalls && cacheable) ? rand_bit() : 1'b1;
        end
        if (exp_hit && !stalls) check_value("hit latency", 2, cycles);
        check_value("burst count", bursts_before + (exp_hit ? 0 : 1), burst_count);
        if (cacheable && !exp_hit) begin
            check_value("mem_araddr", int'(addr & ~addr_t'((4 << line_sel_width) - 1)),
                        int'(last_ar_addr));
            check_value("mem_arlen", (2 ** line_sel_width) - 1, int'(last_ar_len));
            check_value("mem_arburst", 1, int'(last_ar_burst));
        end else if (!cacheable) begin
            check_value("mem_araddr", int'(addr), int'(last_ar_addr));
            check_value("mem_arlen", 0, int'(last_ar_len));
            check_value("mem_arburst", 0, int'(last_ar_burst));
        end
        check_counters();
        @(posedge clock);
        ifu_rready <= 1'b1;
    endtask

    initial begin
        addr_t addr;
        ifu_arvalid = 1'b0;
        ifu_araddr = '0;
        ifu_rready = 1'b1;
        mem_arready = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata = '0;
        mem_rlast = 1'b0;
        reset = 1'b1;
        flush = 1'b1;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        flush <= 1'b0;
        for (int i = 0; i < num_lines; i++) begin
            ref_valid[i] = 1'b0;
        end

        // Directed miss, hits, bypass and flush
        run_fetch(32'ha0000010, 1'b0);
        if (!timed_out) run_fetch(32'ha0000010, 1'b0);
        if (!timed_out) run_fetch(32'ha0000014, 1'b0);
        if (!timed_out) run_fetch(32'h10000020, 1'b0);
        if (!timed_out) pulse_flush();
        if (!timed_out) run_fetch(32'ha0000010, 1'b0);

        // Random mix with stalls on both sides
        for (int n = 0; n < 300 && !timed_out; n++) begin
            addr = $random(seed);
            if (addr[31]) addr = {8'ha0, 17'h0, addr[6:2], 2'b00};
            else addr = {8'h10, 16'h0, addr[7:2], 2'b00};
            if (($random(seed) & 31) == 0) pulse_flush();
            run_fetch(addr, rand_bit());
        end
        check_counters();

        $display("errors %0d, hits %0d, misses %0d, bypasses %0d",
                 error_count, exp_hits, exp_misses, exp_bypasses);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: fetch_cache_checker.sv
`timescale 1ns/100ps

module fetch_cache_checker (
    input  logic                    clock,
    input  logic                    reset,
    input  icache_pkg::ctrl_state_t state,
    input  icache_pkg::addr_t       ifu_araddr,
    input  logic                    ifu_rvalid,
    input  logic                    ifu_rready,
    input  icache_pkg::word_t       ifu_rdata,
    input  logic                    mem_arvalid,
    input  logic                    mem_arready,
    input  icache_pkg::addr_t       mem_araddr,
    input  logic [7:0]              mem_arlen,
    input  logic                    mem_rvalid,
    input  logic                    mem_rlast
);

    import icache_pkg::*;

    // Beats still owed by the memory for the current burst
    logic [8:0] beats_left;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            beats_left <= '0;
        end else if (mem_arvalid && mem_arready) begin
            beats_left <= {1'b0, mem_arlen} + 9'd1;
        end else if (mem_rvalid && beats_left != 9'd0) begin
            beats_left <= beats_left - 9'd1;
        end
    end

    // ------------------------------------------------------------
    // Handshake stability
    // ------------------------------------------------------------

    a_rvalid_hold: assert property (@(posedge clock) disable iff (reset)
        ifu_rvalid && !ifu_rready |=> ifu_rvalid && $stable(ifu_rdata))
        else $error("ifu_rvalid or ifu_rdata changed before the read transfer");

    a_arvalid_hold: assert property (@(posedge clock) disable iff (reset)
        mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr))
        else $error("mem_arvalid or mem_araddr changed before the address transfer");

    // ------------------------------------------------------------
    // Burst framing
    // ------------------------------------------------------------

    a_beat_expected: assert property (@(posedge clock) disable iff (reset)
        mem_rvalid |-> beats_left != 9'd0)
        else $error("read beat outside a burst");

    a_rlast_position: assert property (@(posedge clock) disable iff (reset)
        mem_rvalid |-> (mem_rlast == (beats_left == 9'd1)))
        else $error("mem_rlast not on the last beat of the burst");

    a_no_idle_rvalid: assert property (@(posedge clock) disable iff (reset)
        (state == st_idle) && (ifu_araddr[31:24] == cacheable_base) |-> !ifu_rvalid)
        else $error("ifu_rvalid high in idle for a cacheable address");

endmodule

// File: fetch_cache_top.sv
`timescale 1ns/100ps

module fetch_cache_top #(
    parameter int index_width = 2,
    parameter int line_sel_width = 1
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    flush,

    // Fetch side, slave
    input  logic                    ifu_arvalid,
    output logic                    ifu_arready,
    input  icache_pkg::addr_t       ifu_araddr,
    output logic                    ifu_rvalid,
    input  logic                    ifu_rready,
    output icache_pkg::word_t       ifu_rdata,
    output logic                    ifu_rlast,

    // Memory side, master
    output logic                    mem_arvalid,
    input  logic                    mem_arready,
    output icache_pkg::addr_t       mem_araddr,
    output logic [7:0]              mem_arlen,
    output logic [1:0]              mem_arburst,
    input  logic                    mem_rvalid,
    output logic                    mem_rready,
    input  icache_pkg::word_t       mem_rdata,
    input  logic                    mem_rlast,

    output icache_pkg::perf_count_t hit_count,
    output icache_pkg::perf_count_t miss_count,
    output icache_pkg::perf_count_t bypass_count
);

    import icache_pkg::*;

    localparam int tag_width = $bits(addr_t) - offset_width - index_width - line_sel_width;

    logic [index_width-1:0]    lookup_index;
    logic [tag_width-1:0]      lookup_tag;
    logic [line_sel_width-1:0] lookup_sel;
    logic                      alloc;
    logic [tag_width-1:0]      alloc_tag;
    logic                      fill_en;
    logic [line_sel_width-1:0] fill_sel;
    word_t                     fill_data;
    logic                      line_hit;
    word_t                     line_word;
    logic                      hit_event;
    logic                      miss_event;
    logic                      bypass_event;

    icache_ctrl #(
        .index_width    (index_width),
        .line_sel_width (line_sel_width)
    ) u_ctrl (
        .clock        (clock),
        .reset        (reset),
        .ifu_arvalid  (ifu_arvalid),
        .ifu_arready  (ifu_arready),
        .ifu_araddr   (ifu_araddr),
        .ifu_rvalid   (ifu_rvalid),
        .ifu_rready   (ifu_rready),
        .ifu_rdata    (ifu_rdata),
        .ifu_rlast    (ifu_rlast),
        .mem_arvalid  (mem_arvalid),
        .mem_arready  (mem_arready),
        .mem_araddr   (mem_araddr),
        .mem_arlen    (mem_arlen),
        .mem_arburst  (mem_arburst),
        .mem_rvalid   (mem_rvalid),
        .mem_rready   (mem_rready),
        .mem_rdata    (mem_rdata),
        .mem_rlast    (mem_rlast),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .lookup_sel   (lookup_sel),
        .alloc        (alloc),
        .alloc_tag    (alloc_tag),
        .fill_en      (fill_en),
        .fill_sel     (fill_sel),
        .fill_data    (fill_data),
        .line_hit     (line_hit),
        .line_word    (line_word),
        .hit_event    (hit_event),
        .miss_event   (miss_event),
        .bypass_event (bypass_event)
    );

    icache_line_store #(
        .index_width    (index_width),
        .line_sel_width (line_sel_width)
    ) u_line_store (
        .clock        (clock),
        .reset        (reset),
        .flush        (flush),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .lookup_sel   (lookup_sel),
        .alloc        (alloc),
        .alloc_tag    (alloc_tag),
        .fill_en      (fill_en),
        .fill_sel     (fill_sel),
        .fill_data    (fill_data),
        .line_hit     (line_hit),
        .line_word    (line_word)
    );

    icache_perf_count u_perf_count (
        .clock        (clock),
        .reset        (reset),
        .hit_event    (hit_event),
        .miss_event   (miss_event),
        .bypass_event (bypass_event),
        .hit_count    (hit_count),
        .miss_count   (miss_count),
        .bypass_count (bypass_count)
    );

endmodule

// File: icache_perf_count.sv
`timescale 1ns/100ps

module icache_perf_count (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    hit_event,
    input  logic                    miss_event,
    input  logic                    bypass_event,
    output icache_pkg::perf_count_t hit_count,
    output icache_pkg::perf_count_t miss_count,
    output icache_pkg::perf_count_t bypass_count
);

    import icache_pkg::*;

    localparam int num_counters = 3;

    logic [num_counters-1:0] events;
    perf_count_t             counts [num_counters];

    // Slot 0 hit, 1 miss, 2 bypass
    assign events = {bypass_event, miss_event, hit_event};

    // ------------------------------------------------------------
    // Counters, wrap silently
    // ------------------------------------------------------------

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_counters; i++) begin
                counts[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_counters; i++) begin
                if (events[i]) begin
                    counts[i] <= counts[i] + 1'b1;
                end
            end
        end
    end

    assign hit_count    = counts[0];
    assign miss_count   = counts[1];
    assign bypass_count = counts[2];

endmodule

// File: icache_ctrl.sv
`timescale 1ns/100ps

module icache_ctrl #(
    parameter int index_width = 2,
    parameter int line_sel_width = 1,
    localparam int tag_width = $bits(icache_pkg::addr_t) - icache_pkg::offset_width
                               - index_width - line_sel_width
) (
    input  logic                      clock,
    input  logic                      reset,

    // Fetch side
    input  logic                      ifu_arvalid,
    output logic                      ifu_arready,
    input  icache_pkg::addr_t         ifu_araddr,
    output logic                      ifu_rvalid,
    input  logic                      ifu_rready,
    output icache_pkg::word_t         ifu_rdata,
    output logic                      ifu_rlast,

    // Memory side
    output logic                      mem_arvalid,
    input  logic                      mem_arready,
    output icache_pkg::addr_t         mem_araddr,
    output logic [7:0]                mem_arlen,
    output logic [1:0]                mem_arburst,
    input  logic                      mem_rvalid,
    output logic                      mem_rready,
    input  icache_pkg::word_t         mem_rdata,
    input  logic                      mem_rlast,

    // Line store
    output logic [index_width-1:0]    lookup_index,
    output logic [tag_width-1:0]      lookup_tag,
    output logic [line_sel_width-1:0] lookup_sel,
    output logic                      alloc,
    output logic [tag_width-1:0]      alloc_tag,
    output logic                      fill_en,
    output logic [line_sel_width-1:0] fill_sel,
    output icache_pkg::word_t         fill_data,
    input  logic                      line_hit,
    input  icache_pkg::word_t         line_word,

    // Event strobes
    output logic                      hit_event,
    output logic                      miss_event,
    output logic                      bypass_event
);

    import icache_pkg::*;

    localparam int sel_lsb = offset_width;
    localparam int index_lsb = offset_width + line_sel_width;
    localparam int tag_lsb = index_lsb + index_width;
    localparam logic [7:0] burst_len = 8'((2 ** line_sel_width) - 1);

    // AXI burst encodings
    localparam logic [1:0] burst_fixed = 2'b00;
    localparam logic [1:0] burst_incr = 2'b01;

    ctrl_state_t               state;
    ctrl_state_t               next_state;
    logic                      cacheable;
    logic                      bypass_sel;
    logic                      refill_arvalid;
    logic [line_sel_width-1:0] beat_count;
    addr_t                     line_addr;

    // ------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------

    assign cacheable = (ifu_araddr[31:24] == cacheable_base);

    // Fetch unit holds araddr until its response, so this stays put
    // for the whole bypass read
    assign bypass_sel = (state == st_idle) && !cacheable;

    assign lookup_index = ifu_araddr[tag_lsb-1:index_lsb];
    assign lookup_tag   = ifu_araddr[$bits(addr_t)-1:tag_lsb];
    assign lookup_sel   = ifu_araddr[index_lsb-1:sel_lsb];
    assign line_addr    = {ifu_araddr[$bits(addr_t)-1:index_lsb], {index_lsb{1'b0}}};

    // ------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (ifu_arvalid && cacheable) begin
                    next_state = st_lookup;
                end
            end
            st_lookup: begin
                next_state = line_hit ? st_hit : st_refill;
            end
            st_hit, st_resp: begin
                if (ifu_rready) begin
                    next_state = st_idle;
                end
            end
            st_refill: begin
                if (mem_rvalid && mem_rlast) begin
                    next_state = st_resp;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // Burst request, raised the cycle after allocate
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            refill_arvalid <= 1'b0;
        end else if (alloc) begin
            refill_arvalid <= 1'b1;
        end else if (mem_arready) begin
            refill_arvalid <= 1'b0;
        end
    end

    // Beat counter selects the word written by each refill beat
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            beat_count <= '0;
        end else if (alloc) begin
            beat_count <= '0;
        end else if (fill_en) begin
            beat_count <= beat_count + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Line store control
    // ------------------------------------------------------------

    assign alloc     = (state == st_lookup) && !line_hit;
    assign alloc_tag = lookup_tag;
    assign fill_en   = (state == st_refill) && mem_rvalid;
    assign fill_sel  = beat_count;
    assign fill_data = mem_rdata;

    // ------------------------------------------------------------
    // Port steering
    // ------------------------------------------------------------

    assign mem_rready = 1'b1;

    always_comb begin
        if (bypass_sel) begin
            ifu_arready = mem_arready;
            ifu_rvalid  = mem_rvalid;
            ifu_rdata   = mem_rdata;
            ifu_rlast   = mem_rlast;
            mem_arvalid = ifu_arvalid;
            mem_araddr  = ifu_araddr;
            mem_arlen   = 8'd0;
            mem_arburst = burst_fixed;
        end else begin
            ifu_arready = (state == st_idle);
            ifu_rvalid  = (state == st_hit) || (state == st_resp);
            ifu_rdata   = line_word;
            ifu_rlast   = ifu_rvalid;
            mem_arvalid = refill_arvalid;
            mem_araddr  = line_addr;
            mem_arlen   = burst_len;
            mem_arburst = burst_incr;
        end
    end

    // Counter strobes, one cycle each
    assign hit_event    = (state == st_lookup) && line_hit;
    assign miss_event   = alloc;
    assign bypass_event = bypass_sel && ifu_arvalid && mem_arready;

endmodule

// File: icache_line_store.sv
`timescale 1ns/100ps

module icache_line_store #(
    parameter int index_width = 2,
    parameter int line_sel_width = 1,
    localparam int tag_width = $bits(icache_pkg::addr_t) - icache_pkg::offset_width
                               - index_width - line_sel_width
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      flush,
    input  logic [index_width-1:0]    lookup_index,
    input  logic [tag_width-1:0]      lookup_tag,
    input  logic [line_sel_width-1:0] lookup_sel,
    input  logic                      alloc,
    input  logic [tag_width-1:0]      alloc_tag,
    input  logic                      fill_en,
    input  logic [line_sel_width-1:0] fill_sel,
    input  icache_pkg::word_t         fill_data,
    output logic                      line_hit,
    output icache_pkg::word_t         line_word
);

    import icache_pkg::*;

    localparam int num_lines = 2 ** index_width;
    localparam int words_per_line = 2 ** line_sel_width;

    logic [num_lines-1:0] valid_bits;
    logic [tag_width-1:0] tag_mem [num_lines];
    word_t                data_mem [num_lines][words_per_line];

    // ------------------------------------------------------------
    // Valid bits
    // ------------------------------------------------------------

    // Flush wins over a same-cycle allocate
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (flush) begin
            valid_bits <= '0;
        end else if (alloc) begin
            valid_bits[lookup_index] <= 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Tag and data arrays
    // ------------------------------------------------------------

    // Tag is written when the line is claimed, before its data arrives
    always_ff @(posedge clock) begin
        if (alloc) begin
            tag_mem[lookup_index] <= alloc_tag;
        end
    end

    // One word per refill beat
    always_ff @(posedge clock) begin
        if (fill_en) begin
            data_mem[lookup_index][fill_sel] <= fill_data;
        end
    end

    // Lookup path, read straight off the arrays
    assign line_hit  = valid_bits[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
    assign line_word = data_mem[lookup_index][lookup_sel];

endmodule

// File: icache_pkg.sv
package icache_pkg;

    // ------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------

    // Byte address as issued by the fetch unit
    typedef logic [31:0] addr_t;

    // One instruction word, also one memory beat
    typedef logic [31:0] word_t;

    // Performance counter value, wraps on overflow
    typedef logic [31:0] perf_count_t;

    // Byte-in-word offset bits, every word is 4 bytes
    localparam int offset_width = 2;

    // ------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------

    // Top address byte of the cacheable SRAM window
    localparam logic [7:0] cacheable_base = 8'ha0;

    // ------------------------------------------------------------
    // Controller FSM
    // ------------------------------------------------------------

    // st_idle    accept address, bypass reads steered through here
    // st_lookup  tag compare, allocate on miss
    // st_hit     present word from line
    // st_refill  collect burst beats into the line
    // st_resp    present requested word after refill
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_hit,
        st_refill,
        st_resp
    } ctrl_state_t;

endpackage
